/* verilog/vid_pkg.sv */
// Shared constants for the tile-layer video path.
// Screen timing is cut down to 32x16 visible pixels to keep simulation short.
// Every module refers to these by scoped name, vid_pkg::NAME.

`default_nettype none

package vid_pkg;

    // Counter width, shared by both screen counters
    localparam int CNT_W = 6;

    // Horizontal timing in pixels
    localparam logic [CNT_W-1:0] H_TOTAL  = 6'd48;
    localparam logic [CNT_W-1:0] H_START  = 6'd8;
    localparam logic [CNT_W-1:0] H_ACTIVE = 6'd32;
    localparam logic [CNT_W-1:0] HS_START = 6'd40;
    localparam logic [CNT_W-1:0] HS_END   = 6'd44;

    // Vertical timing in lines
    localparam logic [CNT_W-1:0] V_TOTAL  = 6'd20;
    localparam logic [CNT_W-1:0] V_START  = 6'd2;
    localparam logic [CNT_W-1:0] V_ACTIVE = 6'd16;
    localparam logic [CNT_W-1:0] VS_START = 6'd18;
    localparam logic [CNT_W-1:0] VS_END   = 6'd19;

    // Tile map, 4 columns by 2 rows of 8x8 tiles
    localparam int TILE_COLS = 4;
    localparam int TILE_ROWS = 2;
    localparam int MAP_AW    = 3;
    localparam int COL_W     = 2;
    localparam int TROW_W    = 1;
    localparam int PROW_W    = 3;   // pixel row inside a tile

    // Graphics ROM: {tile code, pixel row}
    localparam int ROM_AW = 11;
    localparam int WORD_W = 32;
    localparam int PXL_W  = 4;

    // Pixel-word buffer and its credit loop
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;
    localparam int CRD_W      = 3;

endpackage

`default_nettype wire

/* verilog/vid_timer.sv */
// Screen timing generator.
// hdump and vdump advance once per pxl_cen. Blanking and sync flags are
// registered from the next count, so they line up with hdump and vdump.
// LHBL and LVBL are high inside the visible area.

`timescale 1ns/1ns
`default_nettype none

module vid_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    output logic [vid_pkg::CNT_W-1:0] hdump,
    output logic [vid_pkg::CNT_W-1:0] vdump,
    output logic                      LHBL,
    output logic                      LVBL,
    output logic                      HS,
    output logic                      VS
);

logic [vid_pkg::CNT_W-1:0] h_nxt;
logic [vid_pkg::CNT_W-1:0] v_nxt;

always_comb begin
    h_nxt = hdump + 1'b1;
    v_nxt = vdump;
    if (hdump == vid_pkg::H_TOTAL - 1'b1) begin
        h_nxt = '0;
        // New line
        if (vdump == vid_pkg::V_TOTAL - 1'b1) begin
            v_nxt = '0;
        end else begin
            v_nxt = vdump + 1'b1;
        end
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        hdump <= '0;
        vdump <= '0;
        LHBL  <= 1'b0;
        LVBL  <= 1'b0;
        HS    <= 1'b0;
        VS    <= 1'b0;
    end else if (pxl_cen) begin
        hdump <= h_nxt;
        vdump <= v_nxt;
        LHBL  <= h_nxt >= vid_pkg::H_START &&
                 h_nxt <  vid_pkg::H_START + vid_pkg::H_ACTIVE;
        LVBL  <= v_nxt >= vid_pkg::V_START &&
                 v_nxt <  vid_pkg::V_START + vid_pkg::V_ACTIVE;
        HS    <= h_nxt >= vid_pkg::HS_START && h_nxt < vid_pkg::HS_END;
        VS    <= v_nxt >= vid_pkg::VS_START && v_nxt < vid_pkg::VS_END;
    end
end

// Line length is exactly H_TOTAL pixels
a_hdump_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    hdump < vid_pkg::H_TOTAL
) else $error("vid_timer: hdump reached H_TOTAL");

endmodule

`default_nettype wire

/* verilog/scr_fetch.sv */
// Scroll-layer fetcher with its tile map RAM.
// The CPU writes and reads tile codes through vram_cs. The fetcher walks
// the visible area in scan order, reads one 32-bit word per tile line from
// the graphics ROM and pushes it to the pixel buffer. A push spends one
// credit and credit_ret gives one back, so the buffer never overflows.

`timescale 1ns/1ns
`default_nettype none

module scr_fetch (
    input  logic                       clk,
    input  logic                       rst_n,
    // CPU port
    input  logic [vid_pkg::MAP_AW-1:0] cpu_addr,
    input  logic [7:0]                 cpu_dout,
    input  logic                       cpu_rnw,
    input  logic                       vram_cs,
    output logic [7:0]                 vram_dout,
    // Graphics ROM
    output logic                       rom_cs,
    output logic [vid_pkg::ROM_AW-1:0] rom_addr,
    input  logic [vid_pkg::WORD_W-1:0] rom_data,
    input  logic                       rom_ok,
    // Credit link to the buffer
    output logic                       pxl_push,
    output logic [vid_pkg::WORD_W-1:0] pxl_word,
    input  logic                       credit_ret
);

logic [7:0] tile_map [0:vid_pkg::TILE_COLS*vid_pkg::TILE_ROWS-1];

logic [vid_pkg::COL_W-1:0]  col;
logic [vid_pkg::PROW_W-1:0] prow;
logic [vid_pkg::TROW_W-1:0] trow;
logic [vid_pkg::CRD_W-1:0]  credits;
logic                       have_word;
logic                       issue;

// CPU access
always_ff @(posedge clk) begin
    if (vram_cs && !cpu_rnw) begin
        tile_map[cpu_addr] <= cpu_dout;
    end
    if (vram_cs && cpu_rnw) begin
        vram_dout <= tile_map[cpu_addr];
    end
end

// A new request starts once the previous word has been pushed
assign issue    = !rom_cs && !have_word;
assign pxl_push = have_word && credits != '0;

// Address and data are latched so a CPU write cannot disturb a fetch
always_ff @(posedge clk) begin
    if (issue) begin
        rom_addr <= {tile_map[{trow, col}], prow};
    end
    if (rom_cs && rom_ok) begin
        pxl_word <= rom_data;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rom_cs    <= 1'b0;
        have_word <= 1'b0;
        credits   <= vid_pkg::CRD_W'(vid_pkg::FIFO_DEPTH);
        col       <= '0;
        prow      <= '0;
        trow      <= '0;
    end else begin
        case ({credit_ret, pxl_push})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
        endcase

        if (issue) begin
            rom_cs <= 1'b1;
        end
        if (rom_cs && rom_ok) begin
            rom_cs    <= 1'b0;
            have_word <= 1'b1;
        end

        // Step to the next tile line in scan order
        if (pxl_push) begin
            have_word <= 1'b0;
            col       <= col + 1'b1;
            if (col == vid_pkg::COL_W'(vid_pkg::TILE_COLS - 1)) begin
                col  <= '0;
                prow <= prow + 1'b1;
                if (prow == '1) begin
                    if (trow == vid_pkg::TROW_W'(vid_pkg::TILE_ROWS - 1)) begin
                        trow <= '0;
                    end else begin
                        trow <= trow + 1'b1;
                    end
                end
            end
        end
    end
end

// Returned credits can never outnumber the words pushed
a_credit_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    credits <= vid_pkg::CRD_W'(vid_pkg::FIFO_DEPTH)
) else $error("scr_fetch: credit count above FIFO_DEPTH");

endmodule

`default_nettype wire

/* verilog/pxl_fifo.sv */
// Pixel-word buffer between the fetcher and the colour mixer.
// Circular buffer of FIFO_DEPTH words. A pushed word is visible on
// fifo_word on the next clock. Every pop sends one credit back to the
// fetcher in the same cycle.

`timescale 1ns/1ns
`default_nettype none

module pxl_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_push,
    input  logic [vid_pkg::WORD_W-1:0] pxl_word,
    input  logic                       pxl_pop,
    output logic [vid_pkg::WORD_W-1:0] fifo_word,
    output logic                       fifo_empty,
    output logic                       credit_ret
);

logic [vid_pkg::WORD_W-1:0]  mem [0:vid_pkg::FIFO_DEPTH-1];
logic [vid_pkg::FIFO_AW-1:0] wr_ptr;
logic [vid_pkg::FIFO_AW-1:0] rd_ptr;
logic [vid_pkg::CRD_W-1:0]   level;
logic                        full;

assign fifo_empty = level == '0;
assign full       = level == vid_pkg::CRD_W'(vid_pkg::FIFO_DEPTH);
assign fifo_word  = mem[rd_ptr];
assign credit_ret = pxl_pop && !fifo_empty;

always_ff @(posedge clk) begin
    if (pxl_push) begin
        mem[wr_ptr] <= pxl_word;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        level  <= '0;
    end else begin
        if (pxl_push) wr_ptr <= wr_ptr + 1'b1;
        if (credit_ret) rd_ptr <= rd_ptr + 1'b1;
        case ({pxl_push, credit_ret})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
        endcase
    end
end

// The fetcher's credit count must keep it from overrunning the buffer
a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    pxl_push |-> !full
) else $error("pxl_fifo: push while full");

a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    pxl_pop |-> !fifo_empty
) else $error("pxl_fifo: pop while empty");

endmodule

`default_nettype wire

/* verilog/vid_colmix.sv */
// Colour mixer.
// Holds the current graphics word in a shift register and sends out one
// pixel per visible pxl_cen, lowest nibble first. The next word is popped
// as soon as the register runs dry. Pixels go through a 16-entry palette
// PROM loaded over prog_addr/prog_data. Output lags its LHBL/LVBL sample
// by one pxl_cen, and so do LHBL_dly and LVBL_dly.

`timescale 1ns/1ns
`default_nettype none

module vid_colmix (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       LHBL,
    input  logic                       LVBL,
    input  logic [vid_pkg::WORD_W-1:0] fifo_word,
    input  logic                       fifo_empty,
    output logic                       pxl_pop,
    // Palette PROM programming
    input  logic [vid_pkg::PXL_W-1:0]  prog_addr,
    input  logic [7:0]                 prog_data,
    input  logic                       prom_en,
    // Video out
    output logic [3:0]                 red,
    output logic [3:0]                 green,
    output logic [3:0]                 blue,
    output logic                       LHBL_dly,
    output logic                       LVBL_dly
);

logic [7:0]                 prom [0:2**vid_pkg::PXL_W-1];
logic [vid_pkg::WORD_W-1:0] shreg;
logic [vid_pkg::WORD_W/vid_pkg::PXL_W-1:0] pxl_vld;   // one bit per pixel left
logic [7:0]                 pal;
logic                       shift;

assign pxl_pop = !pxl_vld[0] && !fifo_empty;
assign shift   = pxl_cen && LHBL && LVBL && pxl_vld[0];
assign pal     = prom[shreg[vid_pkg::PXL_W-1:0]];

always_ff @(posedge clk) begin
    if (prom_en) begin
        prom[prog_addr] <= prog_data;
    end
    if (pxl_pop) begin
        shreg <= fifo_word;
    end else if (shift) begin
        shreg <= shreg >> vid_pkg::PXL_W;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pxl_vld  <= '0;
        red      <= '0;
        green    <= '0;
        blue     <= '0;
        LHBL_dly <= 1'b0;
        LVBL_dly <= 1'b0;
    end else begin
        if (pxl_pop) begin
            pxl_vld <= '1;
        end else if (shift) begin
            pxl_vld <= pxl_vld >> 1;
        end
        if (pxl_cen) begin
            LHBL_dly <= LHBL;
            LVBL_dly <= LVBL;
            // Packing is BBGGGRRR
            if (LHBL && LVBL) begin
                red   <= {pal[2:0], pal[2]};
                green <= {pal[5:3], pal[5]};
                blue  <= {pal[7:6], pal[7:6]};
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end
end

// The fetcher and buffer must keep ahead of the visible scan
a_no_underrun: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pxl_cen && LHBL && LVBL) |-> pxl_vld[0]
) else $error("vid_colmix: pixel data underrun");

endmodule

`default_nettype wire

/* verilog/vid_top.sv */
// Tile-layer video path, top level.
// Joins the screen timer, the scroll fetcher, the pixel-word buffer and
// the colour mixer. The graphics ROM and the pixel clock enable come
// from outside.

`timescale 1ns/1ns
`default_nettype none

module vid_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    // CPU interface
    input  logic [vid_pkg::MAP_AW-1:0] cpu_addr,
    input  logic [7:0]                 cpu_dout,
    input  logic                       cpu_rnw,
    input  logic                       vram_cs,
    output logic [7:0]                 vram_dout,
    // Graphics ROM
    output logic                       rom_cs,
    output logic [vid_pkg::ROM_AW-1:0] rom_addr,
    input  logic [vid_pkg::WORD_W-1:0] rom_data,
    input  logic                       rom_ok,
    // Palette PROM
    input  logic [vid_pkg::PXL_W-1:0]  prog_addr,
    input  logic [7:0]                 prog_data,
    input  logic                       prom_en,
    // Video
    output logic                       HS,
    output logic                       VS,
    output logic                       LHBL_dly,
    output logic                       LVBL_dly,
    output logic [3:0]                 red,
    output logic [3:0]                 green,
    output logic [3:0]                 blue
);

logic                       LHBL, LVBL;
logic                       pxl_push, pxl_pop, credit_ret, fifo_empty;
logic [vid_pkg::WORD_W-1:0] pxl_word, fifo_word;

vid_timer u_timer (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .hdump      (            ),
    .vdump      (            ),
    .LHBL       ( LHBL       ),
    .LVBL       ( LVBL       ),
    .HS         ( HS         ),
    .VS         ( VS         )
);

scr_fetch u_fetch (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_dout   ( cpu_dout   ),
    .cpu_rnw    ( cpu_rnw    ),
    .vram_cs    ( vram_cs    ),
    .vram_dout  ( vram_dout  ),
    .rom_cs     ( rom_cs     ),
    .rom_addr   ( rom_addr   ),
    .rom_data   ( rom_data   ),
    .rom_ok     ( rom_ok     ),
    .pxl_push   ( pxl_push   ),
    .pxl_word   ( pxl_word   ),
    .credit_ret ( credit_ret )
);

pxl_fifo u_fifo (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_push   ( pxl_push   ),
    .pxl_word   ( pxl_word   ),
    .pxl_pop    ( pxl_pop    ),
    .fifo_word  ( fifo_word  ),
    .fifo_empty ( fifo_empty ),
    .credit_ret ( credit_ret )
);

vid_colmix u_colmix (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .LHBL       ( LHBL       ),
    .LVBL       ( LVBL       ),
    .fifo_word  ( fifo_word  ),
    .fifo_empty ( fifo_empty ),
    .pxl_pop    ( pxl_pop    ),
    .prog_addr  ( prog_addr  ),
    .prog_data  ( prog_data  ),
    .prom_en    ( prom_en    ),
    .red        ( red        ),
    .green      ( green      ),
    .blue       ( blue       ),
    .LHBL_dly   ( LHBL_dly   ),
    .LVBL_dly   ( LVBL_dly   )
);

endmodule

`default_nettype wire

/* bench/vid_tb.sv */
// Testbench for the tile-layer video path.
// Drives vid_top with a pixel enable every 4 clocks, a graphics ROM model
// with random latency, and CPU and palette programming traffic. Directed
// tasks check reset state, tile map access, screen timing and whole frames
// of pixels against values predicted from the tile map, the ROM data rule,
// the nibble order and the palette packing.

`timescale 1ns/1ns
`default_nettype none

module vid_tb;

// Selectors for the flag probe
localparam int SEL_HS   = 0;
localparam int SEL_LHBL = 1;
localparam int SEL_LVBL = 2;

localparam int FRAME_CENS = int'(vid_pkg::H_TOTAL) * int'(vid_pkg::V_TOTAL);
localparam int SCREEN_W   = int'(vid_pkg::H_ACTIVE);
localparam int SCREEN_H   = int'(vid_pkg::V_ACTIVE);

logic                       clk;
logic                       rst_n;
logic                       pxl_cen;
logic [vid_pkg::MAP_AW-1:0] cpu_addr;
logic [7:0]                 cpu_dout;
logic                       cpu_rnw;
logic                       vram_cs;
logic [7:0]                 vram_dout;
logic                       rom_cs;
logic [vid_pkg::ROM_AW-1:0] rom_addr;
logic [vid_pkg::WORD_W-1:0] rom_data;
logic                       rom_ok;
logic [vid_pkg::PXL_W-1:0]  prog_addr;
logic [7:0]                 prog_data;
logic                       prom_en;
logic                       HS;
logic                       VS;
logic                       LHBL_dly;
logic                       LVBL_dly;
logic [3:0]                 red;
logic [3:0]                 green;
logic [3:0]                 blue;

// Reference copies of what was programmed
logic [7:0] map_model [0:vid_pkg::TILE_COLS*vid_pkg::TILE_ROWS-1];
logic [7:0] pal_model [0:2**vid_pkg::PXL_W-1];

logic slow_rom;
logic addr_check;
int   fetch_idx;
int   rom_left;
int   checks;
int   errors;

vid_top i_dut (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .pxl_cen   ( pxl_cen   ),
    .cpu_addr  ( cpu_addr  ),
    .cpu_dout  ( cpu_dout  ),
    .cpu_rnw   ( cpu_rnw   ),
    .vram_cs   ( vram_cs   ),
    .vram_dout ( vram_dout ),
    .rom_cs    ( rom_cs    ),
    .rom_addr  ( rom_addr  ),
    .rom_data  ( rom_data  ),
    .rom_ok    ( rom_ok    ),
    .prog_addr ( prog_addr ),
    .prog_data ( prog_data ),
    .prom_en   ( prom_en   ),
    .HS        ( HS        ),
    .VS        ( VS        ),
    .LHBL_dly  ( LHBL_dly  ),
    .LVBL_dly  ( LVBL_dly  ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      )
);

initial begin : clk_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// One-clock pixel enable every fourth clock
initial begin : cen_gen
    int phase;
    pxl_cen = 1'b0;
    phase   = 0;
    forever begin
        @(negedge clk);
        phase   = (phase + 1) % 4;
        pxl_cen = phase == 0;
    end
end

// Nibble i of a ROM word is the low address nibble plus i
function automatic logic [vid_pkg::WORD_W-1:0] rom_word(input logic [vid_pkg::ROM_AW-1:0] addr);
    logic [vid_pkg::WORD_W-1:0] w;
    w = '0;
    for (int i = 0; i < 8; i++) begin
        w[i*4 +: 4] = addr[3:0] + 4'(i);
    end
    return w;
endfunction

// Graphics ROM address of the n-th word fetched since reset, in scan order
function automatic logic [vid_pkg::ROM_AW-1:0] scan_addr(input int n);
    int col;
    int prow;
    int trow;
    col  = n % vid_pkg::TILE_COLS;
    prow = (n / vid_pkg::TILE_COLS) % 8;
    trow = (n / (vid_pkg::TILE_COLS * 8)) % vid_pkg::TILE_ROWS;
    return {map_model[trow * vid_pkg::TILE_COLS + col], 3'(prow)};
endfunction

// ROM answers each request after 1 to 6 clocks, or always 6 when slow
initial begin : rom_model
    void'($urandom(32'h3dfa_3a6f));
    rom_ok    = 1'b0;
    rom_data  = '0;
    rom_left  = 0;
    fetch_idx = 0;
    forever begin
        @(negedge clk);
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (rom_left == 0) begin
                rom_left = slow_rom ? 6 : 1 + int'($urandom % 6);
            end
            rom_left = rom_left - 1;
            if (rom_left == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
                if (addr_check) begin
                    compare($sformatf("rom address %0d", fetch_idx),
                            32'(scan_addr(fetch_idx)), 32'(rom_addr));
                end
                fetch_idx++;
            end
        end
    end
end

// Palette byte is BBGGGRRR, widened to 4 bits per channel
function automatic logic [11:0] colour_of(input logic [vid_pkg::PXL_W-1:0] pxl);
    logic [7:0] p;
    p = pal_model[pxl];
    return {p[2:0], p[2], p[5:3], p[5], p[7:6], p[7:6]};
endfunction

function automatic logic [11:0] expect_pixel(input int x, input int y);
    logic [7:0]                 code;
    logic [vid_pkg::WORD_W-1:0] word;
    code = map_model[(y / 8) * vid_pkg::TILE_COLS + x / 8];
    word = rom_word({code, 3'(y % 8)});
    return colour_of(word[(x % 8) * vid_pkg::PXL_W +: vid_pkg::PXL_W]);
endfunction

task automatic compare(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
    end
endtask

task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("TEST FAILED");
    $finish;
endtask

// Returns on the falling edge after a clock that carried pxl_cen
task automatic wait_cen();
    int n;
    n = 0;
    @(posedge clk);
    while (!pxl_cen) begin
        n++;
        if (n > 8) stop_on_timeout("pxl_cen");
        @(posedge clk);
    end
    @(negedge clk);
endtask

function automatic logic probe(input int sel);
    case (sel)
        SEL_HS:   return HS;
        SEL_LHBL: return LHBL_dly;
        default:  return LVBL_dly;
    endcase
endfunction

task automatic wait_for_level(input int sel, input logic level, input string what,
                              output int cens);
    cens = 0;
    while (probe(sel) !== level) begin
        wait_cen();
        cens++;
        if (cens > 2 * FRAME_CENS) stop_on_timeout(what);
    end
endtask

task automatic load_map(input int base, input int step);
    for (int i = 0; i < vid_pkg::TILE_COLS * vid_pkg::TILE_ROWS; i++) begin
        @(negedge clk);
        map_model[i] = 8'(base + i * step);
        vram_cs  = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_addr = vid_pkg::MAP_AW'(i);
        cpu_dout = map_model[i];
    end
    @(negedge clk);
    vram_cs = 1'b0;
    cpu_rnw = 1'b1;
endtask

task automatic load_palette(input int base, input int step);
    for (int i = 0; i < 2**vid_pkg::PXL_W; i++) begin
        @(negedge clk);
        pal_model[i] = 8'(base + i * step);
        prog_addr = vid_pkg::PXL_W'(i);
        prog_data = pal_model[i];
        prom_en   = 1'b1;
    end
    @(negedge clk);
    prom_en = 1'b0;
endtask

// Lets one whole frame start and end after the last change, so every
// prefetched word comes from the new map, then checks the next frame
task automatic capture_frame(input string name);
    int n;
    int idx;
    int cens;
    wait_for_level(SEL_LVBL, 1'b0, "vertical blank", n);
    wait_for_level(SEL_LVBL, 1'b1, "frame start", n);
    wait_for_level(SEL_LVBL, 1'b0, "vertical blank", n);
    // Fetches from here on use only the new map
    addr_check = 1'b1;
    wait_for_level(SEL_LVBL, 1'b1, "frame start", n);
    idx  = 0;
    cens = 0;
    while (LVBL_dly) begin
        if (LHBL_dly) begin
            compare($sformatf("%s x=%0d y=%0d", name, idx % SCREEN_W, idx / SCREEN_W),
                    32'(expect_pixel(idx % SCREEN_W, idx / SCREEN_W)),
                    32'({red, green, blue}));
            idx++;
        end
        wait_cen();
        cens++;
        if (cens > FRAME_CENS) stop_on_timeout("end of visible frame");
    end
    addr_check = 1'b0;
    compare({name, " pixel count"}, 32'(SCREEN_W * SCREEN_H), 32'(idx));
endtask

task automatic test_reset();
    repeat (3) @(negedge clk);
    compare("reset rom_cs", 32'h0, 32'(rom_cs));
    compare("reset HS", 32'h0, 32'(HS));
    compare("reset VS", 32'h0, 32'(VS));
    compare("reset colour", 32'h0, 32'({red, green, blue}));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    compare("release rom_cs", 32'h0, 32'(rom_cs));
    repeat (2) wait_cen();
    compare("after reset HS", 32'h0, 32'(HS));
    compare("after reset VS", 32'h0, 32'(VS));
    compare("after reset colour", 32'h0, 32'({red, green, blue}));
endtask

task automatic test_map();
    load_map(8'h07, 8'h1f);
    for (int i = 0; i < vid_pkg::TILE_COLS * vid_pkg::TILE_ROWS; i++) begin
        @(negedge clk);
        vram_cs  = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = vid_pkg::MAP_AW'(i);
        @(negedge clk);
        vram_cs = 1'b0;
        compare($sformatf("tile map read %0d", i), 32'(map_model[i]), 32'(vram_dout));
    end
endtask

task automatic test_timing();
    int   n1;
    int   n2;
    int   lines;
    int   line_pix;
    int   cens;
    logic hb_prev;
    // HS period from one rising edge to the next
    wait_for_level(SEL_HS, 1'b0, "HS low", n1);
    wait_for_level(SEL_HS, 1'b1, "HS rise", n1);
    wait_for_level(SEL_HS, 1'b0, "HS low", n1);
    wait_for_level(SEL_HS, 1'b1, "HS rise", n2);
    compare("cens per HS period", 32'(vid_pkg::H_TOTAL), 32'(n1 + n2));

    wait_for_level(SEL_LVBL, 1'b0, "vertical blank", n1);
    wait_for_level(SEL_LVBL, 1'b1, "frame start", n1);
    lines    = 0;
    line_pix = 0;
    cens     = 0;
    hb_prev  = 1'b0;
    while (LVBL_dly) begin
        if (LHBL_dly) line_pix++;
        if (hb_prev && !LHBL_dly) begin
            lines++;
            compare("visible pixels per line", 32'(vid_pkg::H_ACTIVE), 32'(line_pix));
            line_pix = 0;
        end
        hb_prev = LHBL_dly;
        wait_cen();
        cens++;
        if (cens > FRAME_CENS) stop_on_timeout("end of visible frame");
    end
    compare("visible lines per frame", 32'(vid_pkg::V_ACTIVE), 32'(lines));
endtask

initial begin : main
    rst_n      = 1'b0;
    cpu_addr   = '0;
    cpu_dout   = '0;
    cpu_rnw    = 1'b1;
    vram_cs    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    prom_en    = 1'b0;
    slow_rom   = 1'b0;
    addr_check = 1'b0;
    checks     = 0;
    errors     = 0;

    test_reset();
    test_map();
    test_timing();

    // Same code in every tile, so only the palette varies the picture
    load_palette(8'h29, 8'h17);
    load_map(8'h2c, 8'h00);
    capture_frame("palette");

    load_palette(8'hd3, 8'h3b);
    load_map(8'h13, 8'h35);
    capture_frame("full frame");

    // Longest ROM latency on every request
    slow_rom = 1'b1;
    load_map(8'hc1, 8'h4b);
    capture_frame("back-pressure");
    slow_rom = 1'b0;

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* sources.f */
verilog/vid_pkg.sv
verilog/vid_timer.sv
verilog/scr_fetch.sv
verilog/pxl_fifo.sv
verilog/vid_colmix.sv
verilog/vid_top.sv
bench/vid_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= vid_tb
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
